// File: src/switch_defs.svh
`ifndef SWITCH_DEFS_SVH
`define SWITCH_DEFS_SVH

////////////////////////////////////////////////////////////////////////////
// switch geometry
////////////////////////////////////////////////////////////////////////////

// ingress ports feeding the egress link
`define NUM_PORTS 5

// beat width in bits, strobes are one per byte
`define DATA_WIDTH 32

////////////////////////////////////////////////////////////////////////////
// egress link
////////////////////////////////////////////////////////////////////////////

// beat slots in the downstream buffer
`define EGRESS_CREDITS 4

`endif

// File: src/switch_pkg.sv
`include "switch_defs.svh"

package switch_pkg;

	// one beat and its byte strobes
	typedef logic [`DATA_WIDTH-1:0]     data_t;
	typedef logic [`DATA_WIDTH/8-1:0]   strb_t;

	// sideband fields, held for a whole packet
	typedef logic [15:0] pkt_len_t;
	typedef logic [7:0]  port_mask_t;

	// select value for the datapath mux
	typedef logic [2:0] port_idx_t;

	typedef enum logic
	{
		arb_idle,
		arb_busy
	} arb_state_t;

endpackage

// File: src/port_arbiter.sv
`timescale 1ns/1ps
`include "switch_defs.svh"

module port_arbiter
(
	input  logic                  ACLK,
	input  logic                  rst_n,
	input  logic [`NUM_PORTS-1:0] req,
	input  logic                  beat_fire,
	input  logic                  beat_last,
	output switch_pkg::port_idx_t sel,
	output logic                  grant_valid
);
	import switch_pkg::*;

	arb_state_t state;
	port_idx_t  next_sel;
	logic       any_req;

	assign any_req = |req;

	////////////////////////////////////////////////////////////////////////////
	// round-robin pick
	////////////////////////////////////////////////////////////////////////////

	// sel keeps the last winner, so it doubles as the rr pointer.
	// walk from the farthest port back to the nearest, nearest wins
	always_comb
	begin
		int idx;
		next_sel = sel;
		for (int i = `NUM_PORTS; i >= 1; i--)
		begin
			idx = (int'(sel) + i) % `NUM_PORTS;
			if (req[idx])
				next_sel = port_idx_t'(idx);
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// grant fsm
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge ACLK or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state <= arb_idle;
			// port 0 gets first turn out of reset
			sel   <= port_idx_t'(`NUM_PORTS - 1);
		end
		else
		begin
			case (state)
				arb_idle:
				begin
					if (any_req)
					begin
						state <= arb_busy;
						sel   <= next_sel;
					end
				end
				arb_busy:
				begin
					// held for the whole packet
					if (beat_fire && beat_last)
						state <= arb_idle;
				end
				default:
				begin
					state <= arb_idle;
				end
			endcase
		end
	end

	assign grant_valid = (state == arb_busy);

endmodule

// File: src/datapath_mux.sv
`timescale 1ns/1ps
`include "switch_defs.svh"

module datapath_mux
(
	input  switch_pkg::port_idx_t                    sel,
	input  logic                                     grant_valid,
	input  logic                                     credit_ok,
	input  logic [`NUM_PORTS-1:0]                    in_valid,
	input  switch_pkg::data_t [`NUM_PORTS-1:0]       in_data,
	input  switch_pkg::strb_t [`NUM_PORTS-1:0]       in_strb,
	input  logic [`NUM_PORTS-1:0]                    in_last,
	input  switch_pkg::pkt_len_t [`NUM_PORTS-1:0]    in_sb_len,
	input  switch_pkg::port_mask_t [`NUM_PORTS-1:0]  in_sb_dpt,
	input  logic [`NUM_PORTS-1:0]                    in_sb_err,
	output logic [`NUM_PORTS-1:0]                    in_ready,
	output logic                                     beat_fire,
	output switch_pkg::data_t                        beat_data,
	output switch_pkg::strb_t                        beat_strb,
	output logic                                     beat_last,
	output switch_pkg::pkt_len_t                     beat_sb_len,
	output switch_pkg::port_mask_t                   beat_sb_spt,
	output switch_pkg::port_mask_t                   beat_sb_dpt,
	output logic                                     beat_sb_err
);
	import switch_pkg::*;

	logic port_open;

	////////////////////////////////////////////////////////////////////////////
	// handshake back to the ingress ports
	////////////////////////////////////////////////////////////////////////////

	// granted port may move a beat when the link has room
	assign port_open = grant_valid && credit_ok;
	assign beat_fire = port_open && in_valid[sel];

	always_comb
	begin
		in_ready      = '0;
		in_ready[sel] = port_open;
	end

	////////////////////////////////////////////////////////////////////////////
	// beat and sideband select
	////////////////////////////////////////////////////////////////////////////

	// payload only matters on a fired beat
	assign beat_data = in_data[sel];
	assign beat_strb = in_strb[sel];

	always_comb
	begin
		if (beat_fire)
		begin
			beat_last   = in_last[sel];
			beat_sb_len = in_sb_len[sel];
			// source port as a one-hot mask
			beat_sb_spt = port_mask_t'(1) << sel;
			beat_sb_dpt = in_sb_dpt[sel];
			beat_sb_err = in_sb_err[sel];
		end
		else
		begin
			beat_last   = 1'b0;
			beat_sb_len = '0;
			beat_sb_spt = '0;
			beat_sb_dpt = '0;
			beat_sb_err = 1'b0;
		end
	end

endmodule

// File: src/egress_stage.sv
`timescale 1ns/1ps
`include "switch_defs.svh"

module egress_stage
(
	input  logic                   ACLK,
	input  logic                   rst_n,
	input  logic                   beat_fire,
	input  switch_pkg::data_t      beat_data,
	input  switch_pkg::strb_t      beat_strb,
	input  logic                   beat_last,
	input  switch_pkg::pkt_len_t   beat_sb_len,
	input  switch_pkg::port_mask_t beat_sb_spt,
	input  switch_pkg::port_mask_t beat_sb_dpt,
	input  logic                   beat_sb_err,
	input  logic                   credit_return,
	output logic                   credit_ok,
	output logic                   out_valid,
	output switch_pkg::data_t      out_data,
	output switch_pkg::strb_t      out_strb,
	output logic                   out_last,
	output logic                   out_sb_valid,
	output switch_pkg::pkt_len_t   out_sb_len,
	output switch_pkg::port_mask_t out_sb_spt,
	output switch_pkg::port_mask_t out_sb_dpt,
	output logic                   out_sb_err
);
	localparam int CNT_W = $clog2(`EGRESS_CREDITS + 1);

	logic [CNT_W-1:0] credit_cnt;
	logic             sop;

	////////////////////////////////////////////////////////////////////////////
	// output register
	////////////////////////////////////////////////////////////////////////////

	// data and strobes only load on a fired beat
	always_ff @(posedge ACLK)
	begin
		if (beat_fire)
		begin
			out_data <= beat_data;
			out_strb <= beat_strb;
		end
	end

	// sideband arrives zeroed from the mux between beats
	always_ff @(posedge ACLK or negedge rst_n)
	begin
		if (!rst_n)
		begin
			out_valid    <= 1'b0;
			out_last     <= 1'b0;
			out_sb_valid <= 1'b0;
			out_sb_len   <= '0;
			out_sb_spt   <= '0;
			out_sb_dpt   <= '0;
			out_sb_err   <= 1'b0;
			sop          <= 1'b1;
		end
		else
		begin
			out_valid    <= beat_fire;
			out_last     <= beat_last;
			out_sb_valid <= beat_fire && sop;
			out_sb_len   <= beat_sb_len;
			out_sb_spt   <= beat_sb_spt;
			out_sb_dpt   <= beat_sb_dpt;
			out_sb_err   <= beat_sb_err;
			// next beat opens a packet if this one closed one
			if (beat_fire)
				sop <= beat_last;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// credit counter
	////////////////////////////////////////////////////////////////////////////

	// spent when the beat is taken, so back-to-back fires cannot overrun
	always_ff @(posedge ACLK or negedge rst_n)
	begin
		if (!rst_n)
			credit_cnt <= CNT_W'(`EGRESS_CREDITS);
		else
		begin
			case ({beat_fire, credit_return})
				2'b10:   credit_cnt <= credit_cnt - CNT_W'(1);
				2'b01:   credit_cnt <= credit_cnt + CNT_W'(1);
				default: credit_cnt <= credit_cnt;
			endcase
		end
	end

	assign credit_ok = (credit_cnt != '0);

endmodule

// File: src/switch_egress.sv
`timescale 1ns/1ps
`include "switch_defs.svh"

module switch_egress
(
	input  logic                                     ACLK,
	input  logic                                     rst_n,
	input  logic [`NUM_PORTS-1:0]                    in_valid,
	input  switch_pkg::data_t [`NUM_PORTS-1:0]       in_data,
	input  switch_pkg::strb_t [`NUM_PORTS-1:0]       in_strb,
	input  logic [`NUM_PORTS-1:0]                    in_last,
	input  switch_pkg::pkt_len_t [`NUM_PORTS-1:0]    in_sb_len,
	input  switch_pkg::port_mask_t [`NUM_PORTS-1:0]  in_sb_dpt,
	input  logic [`NUM_PORTS-1:0]                    in_sb_err,
	output logic [`NUM_PORTS-1:0]                    in_ready,
	output logic                                     out_valid,
	output switch_pkg::data_t                        out_data,
	output switch_pkg::strb_t                        out_strb,
	output logic                                     out_last,
	output logic                                     out_sb_valid,
	output switch_pkg::pkt_len_t                     out_sb_len,
	output switch_pkg::port_mask_t                   out_sb_spt,
	output switch_pkg::port_mask_t                   out_sb_dpt,
	output logic                                     out_sb_err,
	input  logic                                     credit_return
);
	import switch_pkg::*;

	port_idx_t  sel;
	logic       grant_valid;
	logic       credit_ok;
	logic       beat_fire;
	data_t      beat_data;
	strb_t      beat_strb;
	logic       beat_last;
	pkt_len_t   beat_sb_len;
	port_mask_t beat_sb_spt;
	port_mask_t beat_sb_dpt;
	logic       beat_sb_err;

	// packet-level grant
	port_arbiter port_arbiter_inst
	(
		.ACLK        (ACLK),
		.rst_n       (rst_n),
		.req         (in_valid),
		.beat_fire   (beat_fire),
		.beat_last   (beat_last),
		.sel         (sel),
		.grant_valid (grant_valid)
	);

	datapath_mux datapath_mux_inst
	(
		.sel         (sel),
		.grant_valid (grant_valid),
		.credit_ok   (credit_ok),
		.in_valid    (in_valid),
		.in_data     (in_data),
		.in_strb     (in_strb),
		.in_last     (in_last),
		.in_sb_len   (in_sb_len),
		.in_sb_dpt   (in_sb_dpt),
		.in_sb_err   (in_sb_err),
		.in_ready    (in_ready),
		.beat_fire   (beat_fire),
		.beat_data   (beat_data),
		.beat_strb   (beat_strb),
		.beat_last   (beat_last),
		.beat_sb_len (beat_sb_len),
		.beat_sb_spt (beat_sb_spt),
		.beat_sb_dpt (beat_sb_dpt),
		.beat_sb_err (beat_sb_err)
	);

	// one register stage plus credits toward the downstream
	egress_stage egress_stage_inst
	(
		.ACLK          (ACLK),
		.rst_n         (rst_n),
		.beat_fire     (beat_fire),
		.beat_data     (beat_data),
		.beat_strb     (beat_strb),
		.beat_last     (beat_last),
		.beat_sb_len   (beat_sb_len),
		.beat_sb_spt   (beat_sb_spt),
		.beat_sb_dpt   (beat_sb_dpt),
		.beat_sb_err   (beat_sb_err),
		.credit_return (credit_return),
		.credit_ok     (credit_ok),
		.out_valid     (out_valid),
		.out_data      (out_data),
		.out_strb      (out_strb),
		.out_last      (out_last),
		.out_sb_valid  (out_sb_valid),
		.out_sb_len    (out_sb_len),
		.out_sb_spt    (out_sb_spt),
		.out_sb_dpt    (out_sb_dpt),
		.out_sb_err    (out_sb_err)
	);

endmodule

// File: tb/switch_egress_tb.sv
`timescale 1ns/1ps
`include "switch_defs.svh"

module switch_egress_tb;
	import switch_pkg::*;

	localparam int MAX_PKTS       = 64;
	localparam int TIMEOUT_CYCLES = 20000;

	logic                         ACLK          = 1'b0;
	logic                         rst_n         = 1'b0;
	logic [`NUM_PORTS-1:0]        in_valid      = '0;
	data_t [`NUM_PORTS-1:0]       in_data       = '0;
	strb_t [`NUM_PORTS-1:0]       in_strb       = '0;
	logic [`NUM_PORTS-1:0]        in_last       = '0;
	pkt_len_t [`NUM_PORTS-1:0]    in_sb_len     = '0;
	port_mask_t [`NUM_PORTS-1:0]  in_sb_dpt     = '0;
	logic [`NUM_PORTS-1:0]        in_sb_err     = '0;
	logic                         credit_return = 1'b0;
	logic [`NUM_PORTS-1:0]        in_ready;
	logic                         out_valid;
	data_t                        out_data;
	strb_t                        out_strb;
	logic                         out_last;
	logic                         out_sb_valid;
	pkt_len_t                     out_sb_len;
	port_mask_t                   out_sb_spt;
	port_mask_t                   out_sb_dpt;
	logic                         out_sb_err;

	// packet table from the test file
	int         num_pkts = 0;
	int         pkt_port  [MAX_PKTS];
	int         pkt_beats [MAX_PKTS];
	pkt_len_t   pkt_len   [MAX_PKTS];
	port_mask_t pkt_dpt   [MAX_PKTS];
	logic       pkt_err   [MAX_PKTS];

	// per-port driver state
	int          cur_pkt  [`NUM_PORTS];
	int          cur_beat [`NUM_PORTS];
	int          idle_gap [`NUM_PORTS];
	int          drv_scan [`NUM_PORTS];
	logic [31:0] drv_rng;

	// monitor and downstream model
	int          mon_pkt;
	int          mon_port;
	int          mon_beat;
	int          mon_scan [`NUM_PORTS];
	int          rx_beats;
	int          credits_back;
	int          credit_wait;
	int          done_pkts = 0;
	logic [31:0] crd_rng;

	switch_egress switch_egress_inst
	(
		.ACLK          (ACLK),
		.rst_n         (rst_n),
		.in_valid      (in_valid),
		.in_data       (in_data),
		.in_strb       (in_strb),
		.in_last       (in_last),
		.in_sb_len     (in_sb_len),
		.in_sb_dpt     (in_sb_dpt),
		.in_sb_err     (in_sb_err),
		.in_ready      (in_ready),
		.out_valid     (out_valid),
		.out_data      (out_data),
		.out_strb      (out_strb),
		.out_last      (out_last),
		.out_sb_valid  (out_sb_valid),
		.out_sb_len    (out_sb_len),
		.out_sb_spt    (out_sb_spt),
		.out_sb_dpt    (out_sb_dpt),
		.out_sb_err    (out_sb_err),
		.credit_return (credit_return)
	);

	always #5 ACLK = ~ACLK;

	////////////////////////////////////////////////////////////////////////////
	// helpers
	////////////////////////////////////////////////////////////////////////////

	function automatic logic [31:0] xorshift32(logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// port in the top byte, packet number next, beat index below
	function automatic data_t beat_word(int port, int pkt, int beat);
		return {port[7:0], pkt[7:0], beat[15:0]};
	endfunction

	// partial strobe only on the closing beat
	function automatic strb_t beat_strobe(pkt_len_t len, logic last);
		int tail;
		tail = int'(len) % 4;
		if (!last || tail == 0)
			return '1;
		return strb_t'((1 << tail) - 1);
	endfunction

	function automatic int next_packet_of(int port, int from);
		for (int i = from; i < num_pkts; i++)
		begin
			if (pkt_port[i] == port)
				return i;
		end
		return -1;
	endfunction

	task automatic end_in_failure();
		$display("sim failed");
		$fatal(1, "stopping at the first error");
	endtask

	task automatic report_mismatch(string msg);
		$display("FAIL at %0d ns: %s", $time, msg);
		end_in_failure();
	endtask

	task automatic load_tests();
		int    fd;
		int    nread;
		int    port_v;
		int    dpt_v;
		int    beats_v;
		int    len_v;
		int    err_v;
		string line;
		fd = $fopen("tb/switch_egress_tests.txt", "r");
		if (fd == 0)
		begin
			$display("could not open tb/switch_egress_tests.txt");
			end_in_failure();
		end
		while (!$feof(fd) && num_pkts < MAX_PKTS)
		begin
			nread = $fgets(line, fd);
			// comment and blank lines do not scan
			if (nread > 0 &&
				$sscanf(line, "%d %h %d %d %d", port_v, dpt_v, beats_v, len_v, err_v) == 5)
			begin
				if (port_v < 0 || port_v >= `NUM_PORTS || beats_v < 1)
				begin
					$display("test file line has a bad port or beat count: %s", line);
					end_in_failure();
				end
				pkt_port[num_pkts]  = port_v;
				pkt_beats[num_pkts] = beats_v;
				pkt_len[num_pkts]   = pkt_len_t'(len_v);
				pkt_dpt[num_pkts]   = port_mask_t'(dpt_v);
				pkt_err[num_pkts]   = (err_v != 0);
				num_pkts++;
			end
		end
		$fclose(fd);
		if (num_pkts == 0)
		begin
			$display("test file holds no packets");
			end_in_failure();
		end
	endtask

	task automatic check_idle_outputs();
		assert (out_valid == 1'b0 && out_sb_valid == 1'b0 && in_ready == '0)
		else
			report_mismatch($sformatf("out_valid %b out_sb_valid %b in_ready %b around reset",
				out_valid, out_sb_valid, in_ready));
	endtask

	////////////////////////////////////////////////////////////////////////////
	// ingress drivers
	////////////////////////////////////////////////////////////////////////////

	task automatic drive_beat(int k);
		int   i;
		logic last;
		i    = cur_pkt[k];
		last = (cur_beat[k] == pkt_beats[i] - 1);
		in_valid[k]  <= 1'b1;
		in_data[k]   <= beat_word(k, i, cur_beat[k]);
		in_strb[k]   <= beat_strobe(pkt_len[i], last);
		in_last[k]   <= last;
		in_sb_len[k] <= pkt_len[i];
		in_sb_dpt[k] <= pkt_dpt[i];
		in_sb_err[k] <= pkt_err[i];
	endtask

	task automatic step_port(int k);
		if (cur_pkt[k] >= 0)
		begin
			if (in_valid[k] && in_ready[k])
			begin
				if (cur_beat[k] == pkt_beats[cur_pkt[k]] - 1)
				begin
					in_valid[k] <= 1'b0;
					in_last[k]  <= 1'b0;
					cur_pkt[k]  = -1;
					drv_rng     = xorshift32(drv_rng);
					idle_gap[k] = int'(drv_rng[1:0]);
				end
				else
				begin
					cur_beat[k]++;
					drive_beat(k);
				end
			end
		end
		else if (idle_gap[k] > 0)
			idle_gap[k]--;
		else
		begin
			cur_pkt[k] = next_packet_of(k, drv_scan[k]);
			if (cur_pkt[k] >= 0)
			begin
				drv_scan[k] = cur_pkt[k] + 1;
				cur_beat[k] = 0;
				drive_beat(k);
			end
		end
	endtask

	always @(posedge ACLK)
	begin
		if (!rst_n)
		begin
			drv_rng = 32'd19992;
			for (int k = 0; k < `NUM_PORTS; k++)
			begin
				cur_pkt[k]  = -1;
				cur_beat[k] = 0;
				idle_gap[k] = 0;
				drv_scan[k] = 0;
			end
		end
		else
		begin
			for (int k = 0; k < `NUM_PORTS; k++)
				step_port(k);
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// egress monitor and credit returner
	////////////////////////////////////////////////////////////////////////////

	task automatic check_beat();
		int   p;
		int   i;
		logic last;
		p = -1;
		if (mon_pkt < 0)
		begin
			for (int k = 0; k < `NUM_PORTS; k++)
			begin
				if (out_sb_spt == (port_mask_t'(1) << k))
					p = k;
			end
			assert (out_sb_valid && p >= 0)
			else
				report_mismatch($sformatf("packet start with sb_valid %b source mask %b",
					out_sb_valid, out_sb_spt));
			i = next_packet_of(p, mon_scan[p]);
			assert (i >= 0)
			else
				report_mismatch($sformatf("port %0d sent more packets than the file", p));
			mon_pkt     = i;
			mon_port    = p;
			mon_beat    = 0;
			mon_scan[p] = i + 1;
		end
		else
		begin
			assert (!out_sb_valid)
			else
				report_mismatch($sformatf("sb_valid on beat %0d of packet %0d",
					mon_beat + 1, mon_pkt));
			mon_beat++;
		end
		i    = mon_pkt;
		last = (mon_beat == pkt_beats[i] - 1);
		assert (out_sb_spt == (port_mask_t'(1) << mon_port))
		else
			report_mismatch($sformatf("source mask %b inside packet %0d from port %0d",
				out_sb_spt, i, mon_port));
		assert (out_sb_len == pkt_len[i] && out_sb_dpt == pkt_dpt[i] && out_sb_err == pkt_err[i])
		else
			report_mismatch($sformatf("packet %0d sideband len %0d dpt %h err %b", i,
				out_sb_len, out_sb_dpt, out_sb_err));
		assert (out_data == beat_word(mon_port, i, mon_beat))
		else
			report_mismatch($sformatf("packet %0d beat %0d data %h expected %h", i, mon_beat,
				out_data, beat_word(mon_port, i, mon_beat)));
		assert (out_strb == beat_strobe(pkt_len[i], last))
		else
			report_mismatch($sformatf("packet %0d beat %0d strobe %b", i, mon_beat, out_strb));
		assert (out_last == last)
		else
			report_mismatch($sformatf("packet %0d beat %0d last %b", i, mon_beat, out_last));
		rx_beats++;
		if (last)
		begin
			done_pkts++;
			mon_pkt = -1;
		end
	endtask

	// downstream frees each slot after a short random delay or now and then a long one
	task automatic return_credit();
		if (rx_beats - credits_back > 0 && credit_wait == 0)
		begin
			credit_return <= 1'b1;
			crd_rng = xorshift32(crd_rng);
			if (crd_rng[3:0] == 4'd0)
				credit_wait = 20 + int'(crd_rng[8:4]);
			else
				credit_wait = int'(crd_rng[1:0]);
		end
		else
		begin
			credit_return <= 1'b0;
			if (credit_wait > 0)
				credit_wait--;
		end
	endtask

	always @(posedge ACLK)
	begin
		if (!rst_n)
		begin
			mon_pkt      = -1;
			mon_port     = 0;
			mon_beat     = 0;
			rx_beats     = 0;
			credits_back = 0;
			credit_wait  = 0;
			done_pkts    = 0;
			crd_rng      = 32'd19992;
			for (int k = 0; k < `NUM_PORTS; k++)
				mon_scan[k] = 0;
		end
		else
		begin
			assert ($onehot0(in_ready))
			else
				report_mismatch($sformatf("in_ready %b on more than one port", in_ready));
			if (out_valid)
				check_beat();
			else
				assert (!out_sb_valid && out_sb_len == '0 && out_sb_spt == '0 &&
					out_sb_dpt == '0 && !out_sb_err)
				else
					report_mismatch("sideband not zero between beats");
			assert (rx_beats - credits_back <= `EGRESS_CREDITS)
			else
				report_mismatch($sformatf("%0d beats outstanding, link holds %0d",
					rx_beats - credits_back, `EGRESS_CREDITS));
			if (credit_return)
				credits_back++;
			return_credit();
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// main sequence
	////////////////////////////////////////////////////////////////////////////

	initial
	begin
		int cycles;
		load_tests();
		for (int c = 0; c < 4; c++)
		begin
			@(negedge ACLK);
			check_idle_outputs();
		end
		@(posedge ACLK);
		rst_n <= 1'b1;
		@(negedge ACLK);
		check_idle_outputs();
		cycles = 0;
		while (done_pkts < num_pkts && cycles < TIMEOUT_CYCLES)
		begin
			@(negedge ACLK);
			cycles++;
		end
		if (done_pkts == num_pkts)
		begin
			$display("sim passed");
			$finish;
		end
		else
		begin
			$display("timed out with %0d of %0d packets received after %0d cycles",
				done_pkts, num_pkts, cycles);
			end_in_failure();
		end
	end

endmodule

// File: verilog.f
+incdir+src
src/switch_pkg.sv
src/port_arbiter.sv
src/datapath_mux.sv
src/egress_stage.sv
src/switch_egress.sv
tb/switch_egress_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the switch egress testbench with Verilator

cd "$(dirname "$0")"
if [ $? -ne 0 ]; then
	echo "cannot enter the project root"
	exit 1
fi

verilator --binary --timing --assert -j 0 \
	--top-module switch_egress_tb \
	-f verilog.f \
	-o Vswitch_egress_tb > build.log 2>&1
if [ $? -ne 0 ]; then
	echo "verilator build did not complete, see build.log"
	exit 1
fi

./obj_dir/Vswitch_egress_tb > sim.log 2>&1
sim_status=$?

if grep -q "sim failed" sim.log; then
	echo "testbench reported an error, see sim.log"
	exit 1
fi
if [ $sim_status -ne 0 ]; then
	echo "simulator exited with status $sim_status, see sim.log"
	exit 1
fi
echo "simulation finished cleanly"
exit 0

// File: tb/switch_egress_tests.txt
# port dest_mask(hex) beats length_bytes err
# one packet per line, sent by each port in file order
0 02 4 16 0
1 04 1 3 0
2 01 3 10 0
3 10 2 8 1
4 08 5 17 0
0 04 2 5 0
1 01 6 24 0
2 10 1 4 0
3 02 3 9 0
4 01 1 1 1
0 08 8 31 0
1 02 2 6 0
2 08 4 14 0
3 04 1 2 0
4 10 3 12 0
0 10 1 4 1
1 08 3 11 0
2 02 2 7 0
3 01 5 20 0
4 04 2 8 0
0 01 3 9 0
1 10 4 13 0
2 04 6 22 1
3 08 2 5 0
4 02 4 15 0
3 10 7 26 0
0 04 5 18 0
1 01 1 4 0
